// File: logic/pinmux_cfg_pkg.sv
//////////////////////////////////////////////////////////////////////
// pad multiplexer configuration types
// register word widths, per-pad configuration layout and the
// register word that is decoded either as configuration or raw data
//////////////////////////////////////////////////////////////////////

package pinmux_cfg_pkg;

  localparam int unsigned RegWidth    = 32;
  localparam int unsigned AddrWidth   = 8;

  // peripheral lines in each direction
  localparam int unsigned NumSig      = 4;
  localparam int unsigned SigIdxWidth = 2;

  typedef enum logic {
    PadGpio   = 1'b0,
    PadPeriph = 1'b1
  } pad_mode_e;

  // one pad configuration register
  typedef struct packed {
    logic [28:0]            reserved;
    pad_mode_e              mode;
    logic [SigIdxWidth-1:0] sig_idx;
  } pad_cfg_t;

  // pad addresses use the cfg view, GPIO words the raw view
  typedef union packed {
    pad_cfg_t            cfg;
    logic [RegWidth-1:0] raw;
  } reg_word_u;

endpackage

// File: logic/pinmux_map_pkg.sv
//////////////////////////////////////////////////////////////////////
// pad multiplexer address map and peripheral signal map
// GPIO word offsets follow the pad configuration registers
//////////////////////////////////////////////////////////////////////

package pinmux_map_pkg;

  // offsets counted after the last pad register
  localparam int unsigned GpioOutAddr = 0;
  localparam int unsigned GpioOeAddr  = 1;
  localparam int unsigned GpioInAddr  = 2;

  // peripheral signal lines selected by sig_idx
  localparam int unsigned SigUart     = 0;
  localparam int unsigned SigSpiSck   = 1;
  localparam int unsigned SigSpiSd    = 2;
  localparam int unsigned SigCan      = 3;

  // level seen by a peripheral input that no pad drives
  localparam logic [pinmux_cfg_pkg::NumSig-1:0] PeriphInIdle = '1;

endpackage

// File: logic/pinmux_cfg_regs.sv
//////////////////////////////////////////////////////////////////////
// pad multiplexer register bank
// per-pad configuration plus GPIO output, enable and input words
// single-cycle valid/ready register bus with error response
//////////////////////////////////////////////////////////////////////

module pinmux_cfg_regs
  import pinmux_cfg_pkg::*;
  import pinmux_map_pkg::*;
#(
  parameter int unsigned NumPads = 22
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  reg_valid_i,
  input  logic                  reg_write_i,
  input  logic [AddrWidth-1:0]  reg_addr_i,
  input  logic [RegWidth-1:0]   reg_wdata_i,
  input  logic [NumPads-1:0]    gpio_in_i,
  output logic                  reg_ready_o,
  output logic                  reg_error_o,
  output logic [RegWidth-1:0]   reg_rdata_o,
  output pad_cfg_t [NumPads-1:0] pad_cfg_o,
  output logic [NumPads-1:0]    gpio_out_o,
  output logic [NumPads-1:0]    gpio_oe_o
);

  localparam logic [AddrWidth-1:0] OutWord = AddrWidth'(NumPads + GpioOutAddr);
  localparam logic [AddrWidth-1:0] OeWord  = AddrWidth'(NumPads + GpioOeAddr);
  localparam logic [AddrWidth-1:0] InWord  = AddrWidth'(NumPads + GpioInAddr);

  pad_cfg_t [NumPads-1:0] pad_cfg_q;
  logic [NumPads-1:0]     gpio_out_q;
  logic [NumPads-1:0]     gpio_oe_q;
  logic                   ready_q;
  logic                   error_q;
  logic [RegWidth-1:0]    rdata_q;

  logic      hit_pad;
  logic      hit_out;
  logic      hit_oe;
  logic      hit_in;
  logic      acc_err;
  logic      do_write;
  reg_word_u wr_word;
  reg_word_u rd_word;
  pad_cfg_t  wr_cfg;

  //////////////////////////////////////////////////////////////////////
  // address decode
  //////////////////////////////////////////////////////////////////////

  assign hit_pad  = (reg_addr_i < AddrWidth'(NumPads));
  assign hit_out  = (reg_addr_i == OutWord);
  assign hit_oe   = (reg_addr_i == OeWord);
  assign hit_in   = (reg_addr_i == InWord);

  // input word is read only
  assign acc_err  = !(hit_pad || hit_out || hit_oe || hit_in) || (hit_in && reg_write_i);
  assign do_write = reg_valid_i && reg_write_i && !acc_err;

  assign wr_word.raw = reg_wdata_i;

  always_comb begin
    wr_cfg          = wr_word.cfg;
    wr_cfg.reserved = '0;
  end

  always_comb begin
    rd_word.raw = '0;
    if (hit_pad) begin
      for (int i = 0; i < NumPads; i++) begin
        if (reg_addr_i == AddrWidth'(i)) begin
          rd_word.cfg = pad_cfg_q[i];
        end
      end
    end else if (hit_out) begin
      rd_word.raw = RegWidth'(gpio_out_q);
    end else if (hit_oe) begin
      rd_word.raw = RegWidth'(gpio_oe_q);
    end else if (hit_in) begin
      rd_word.raw = RegWidth'(gpio_in_i);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // registers
  //////////////////////////////////////////////////////////////////////

  // all pads come up as GPIO inputs
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pad_cfg_q  <= '0;
      gpio_out_q <= '0;
      gpio_oe_q  <= '0;
      ready_q    <= 1'b0;
      error_q    <= 1'b0;
    end else begin
      ready_q <= reg_valid_i;
      error_q <= reg_valid_i && acc_err;
      if (do_write) begin
        if (hit_pad) begin
          for (int i = 0; i < NumPads; i++) begin
            if (reg_addr_i == AddrWidth'(i)) begin
              pad_cfg_q[i] <= wr_cfg;
            end
          end
        end
        if (hit_out) begin
          gpio_out_q <= wr_word.raw[NumPads-1:0];
        end
        if (hit_oe) begin
          gpio_oe_q <= wr_word.raw[NumPads-1:0];
        end
      end
    end
  end

  // response data, zero for writes and errors
  always_ff @(posedge clk_i) begin
    if (reg_valid_i) begin
      rdata_q <= (reg_write_i || acc_err) ? '0 : rd_word.raw;
    end
  end

  assign reg_ready_o = ready_q;
  assign reg_error_o = error_q;
  assign reg_rdata_o = rdata_q;
  assign pad_cfg_o   = pad_cfg_q;
  assign gpio_out_o  = gpio_out_q;
  assign gpio_oe_o   = gpio_oe_q;

endmodule

// File: logic/pad_slice.sv
//////////////////////////////////////////////////////////////////////
// one muxed pad
// output from GPIO bits or a selected peripheral line
//////////////////////////////////////////////////////////////////////

module pad_slice
  import pinmux_cfg_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  pad_cfg_t          cfg_i,
  input  logic              gpio_out_i,
  input  logic              gpio_oe_i,
  input  logic [NumSig-1:0] periph_out_i,
  input  logic [NumSig-1:0] periph_oe_i,
  input  logic              pad_i,
  output logic              pad_o,
  output logic              pad_oe_o,
  output logic              pad_sync_o
);

  logic [1:0] sync_q;

  // output select
  always_comb begin
    if (cfg_i.mode == PadPeriph) begin
      pad_o    = periph_out_i[cfg_i.sig_idx];
      pad_oe_o = periph_oe_i[cfg_i.sig_idx];
    end else begin
      pad_o    = gpio_out_i;
      pad_oe_o = gpio_oe_i;
    end
  end

  // two-flop synchronizer, idles high
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sync_q <= 2'b11;
    end else begin
      sync_q <= {sync_q[0], pad_i};
    end
  end

  assign pad_sync_o = sync_q[1];

endmodule

// File: logic/pinmux_in_router.sv
//////////////////////////////////////////////////////////////////////
// pad input router
// synchronized pad inputs to peripheral inputs and GPIO input word
//////////////////////////////////////////////////////////////////////

module pinmux_in_router
  import pinmux_cfg_pkg::*;
  import pinmux_map_pkg::*;
#(
  parameter int unsigned NumPads = 22
) (
  input  pad_cfg_t [NumPads-1:0] pad_cfg_i,
  input  logic [NumPads-1:0]     pad_sync_i,
  output logic [NumSig-1:0]      periph_in_o,
  output logic [NumPads-1:0]     gpio_in_o
);

  // scan from the top so the lowest matching pad wins
  always_comb begin
    periph_in_o = PeriphInIdle;
    for (int s = 0; s < NumSig; s++) begin
      for (int p = NumPads - 1; p >= 0; p--) begin
        if (pad_cfg_i[p].mode == PadPeriph &&
            pad_cfg_i[p].sig_idx == SigIdxWidth'(s)) begin
          periph_in_o[s] = pad_sync_i[p];
        end
      end
    end
  end

  // GPIO input sees every pad regardless of mode
  assign gpio_in_o = pad_sync_i;

endmodule

// File: logic/astral_pinmux.sv
//////////////////////////////////////////////////////////////////////
// register-configured pad multiplexer
// register bank, one slice per muxed pad and the input router
//////////////////////////////////////////////////////////////////////

module astral_pinmux
  import pinmux_cfg_pkg::*;
#(
  parameter int unsigned NumPads = 22
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 reg_valid_i,
  input  logic                 reg_write_i,
  input  logic [AddrWidth-1:0] reg_addr_i,
  input  logic [RegWidth-1:0]  reg_wdata_i,
  output logic                 reg_ready_o,
  output logic                 reg_error_o,
  output logic [RegWidth-1:0]  reg_rdata_o,
  input  logic [NumSig-1:0]    periph_out_i,
  input  logic [NumSig-1:0]    periph_oe_i,
  output logic [NumSig-1:0]    periph_in_o,
  input  logic [NumPads-1:0]   pad_i,
  output logic [NumPads-1:0]   pad_o,
  output logic [NumPads-1:0]   pad_oe_o
);

  pad_cfg_t [NumPads-1:0] pad_cfg;
  logic [NumPads-1:0]     gpio_out;
  logic [NumPads-1:0]     gpio_oe;
  logic [NumPads-1:0]     gpio_in;
  logic [NumPads-1:0]     pad_sync;

  //////////////////////////////////////////////////////////////////////
  // register bank
  //////////////////////////////////////////////////////////////////////

  pinmux_cfg_regs #(
    .NumPads ( NumPads )
  ) i_cfg_regs (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .reg_valid_i ( reg_valid_i ),
    .reg_write_i ( reg_write_i ),
    .reg_addr_i  ( reg_addr_i  ),
    .reg_wdata_i ( reg_wdata_i ),
    .gpio_in_i   ( gpio_in     ),
    .reg_ready_o ( reg_ready_o ),
    .reg_error_o ( reg_error_o ),
    .reg_rdata_o ( reg_rdata_o ),
    .pad_cfg_o   ( pad_cfg     ),
    .gpio_out_o  ( gpio_out    ),
    .gpio_oe_o   ( gpio_oe     )
  );

  //////////////////////////////////////////////////////////////////////
  // pad slices
  //////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < NumPads; i++) begin : gen_pads
    pad_slice i_pad_slice (
      .clk_i        ( clk_i        ),
      .rst_n_i      ( rst_n_i      ),
      .cfg_i        ( pad_cfg[i]   ),
      .gpio_out_i   ( gpio_out[i]  ),
      .gpio_oe_i    ( gpio_oe[i]   ),
      .periph_out_i ( periph_out_i ),
      .periph_oe_i  ( periph_oe_i  ),
      .pad_i        ( pad_i[i]     ),
      .pad_o        ( pad_o[i]     ),
      .pad_oe_o     ( pad_oe_o[i]  ),
      .pad_sync_o   ( pad_sync[i]  )
    );
  end

  // input side
  pinmux_in_router #(
    .NumPads ( NumPads )
  ) i_in_router (
    .pad_cfg_i   ( pad_cfg     ),
    .pad_sync_i  ( pad_sync    ),
    .periph_in_o ( periph_in_o ),
    .gpio_in_o   ( gpio_in     )
  );

endmodule

// File: verification/astral_pinmux_sva.sv
//////////////////////////////////////////////////////////////////////
// pad multiplexer assertions
// register bus response timing and pad enable sanity
//////////////////////////////////////////////////////////////////////

module astral_pinmux_sva #(
  parameter int unsigned NumPads = 22
) (
  input logic               clk_i,
  input logic               rst_n_i,
  input logic               reg_valid_i,
  input logic               reg_ready_o,
  input logic               reg_error_o,
  input logic [NumPads-1:0] pad_oe_o
);

  // one response per request, one cycle later
  ready_after_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    reg_ready_o |-> $past(reg_valid_i))
    else $error("ready without a request in the previous cycle");

  error_with_ready: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    reg_error_o |-> reg_ready_o)
    else $error("error flag outside a response cycle");

  pad_oe_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !$isunknown(pad_oe_o))
    else $error("pad output enable is unknown");

endmodule

bind astral_pinmux astral_pinmux_sva #(
  .NumPads ( NumPads )
) i_sva (
  .clk_i       ( clk_i       ),
  .rst_n_i     ( rst_n_i     ),
  .reg_valid_i ( reg_valid_i ),
  .reg_ready_o ( reg_ready_o ),
  .reg_error_o ( reg_error_o ),
  .pad_oe_o    ( pad_oe_o    )
);

// File: verification/tb_astral_pinmux.sv
//////////////////////////////////////////////////////////////////////
// pad multiplexer testbench
// random register traffic and pad stimulus against a reference model
//////////////////////////////////////////////////////////////////////

module tb_astral_pinmux;

  localparam int         NumPads = 22;
  localparam int         OutAddr = NumPads;
  localparam int         OeAddr  = NumPads + 1;
  localparam int         InAddr  = NumPads + 2;
  localparam logic [3:0] IdleIn  = 4'hf;

  logic               clk_i;
  logic               rst_n_i;
  logic               reg_valid_i;
  logic               reg_write_i;
  logic [7:0]         reg_addr_i;
  logic [31:0]        reg_wdata_i;
  logic               reg_ready_o;
  logic               reg_error_o;
  logic [31:0]        reg_rdata_o;
  logic [3:0]         periph_out_i;
  logic [3:0]         periph_oe_i;
  logic [3:0]         periph_in_o;
  logic [NumPads-1:0] pad_i;
  logic [NumPads-1:0] pad_o;
  logic [NumPads-1:0] pad_oe_o;

  // model state: {mode, sig_idx} per pad and the GPIO words
  logic [2:0]         cfg_m [NumPads];
  logic [NumPads-1:0] gpio_out_m;
  logic [NumPads-1:0] gpio_oe_m;

  integer      seed;
  int          errors;
  int          mark;
  int          addr;
  logic [31:0] wval;
  logic [31:0] rdata;
  logic        rerr;

  astral_pinmux #(
    .NumPads ( NumPads )
  ) dut0 (
    .clk_i        ( clk_i        ),
    .rst_n_i      ( rst_n_i      ),
    .reg_valid_i  ( reg_valid_i  ),
    .reg_write_i  ( reg_write_i  ),
    .reg_addr_i   ( reg_addr_i   ),
    .reg_wdata_i  ( reg_wdata_i  ),
    .reg_ready_o  ( reg_ready_o  ),
    .reg_error_o  ( reg_error_o  ),
    .reg_rdata_o  ( reg_rdata_o  ),
    .periph_out_i ( periph_out_i ),
    .periph_oe_i  ( periph_oe_i  ),
    .periph_in_o  ( periph_in_o  ),
    .pad_i        ( pad_i        ),
    .pad_o        ( pad_o        ),
    .pad_oe_o     ( pad_oe_o     )
  );

  always #50 clk_i = !clk_i;

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  // expected pad outputs, oe_side picks the enable instead of the data
  function automatic logic [NumPads-1:0] exp_pad(input logic oe_side);
    logic [NumPads-1:0] v;
    for (int p = 0; p < NumPads; p++) begin
      if (cfg_m[p][2]) begin
        v[p] = oe_side ? periph_oe_i[cfg_m[p][1:0]] : periph_out_i[cfg_m[p][1:0]];
      end else begin
        v[p] = oe_side ? gpio_oe_m[p] : gpio_out_m[p];
      end
    end
    return v;
  endfunction

  // first peripheral pad in ascending order takes the input
  function automatic logic [3:0] exp_periph_in(input logic [NumPads-1:0] pads);
    logic [3:0] v;
    logic       found;
    for (int s = 0; s < 4; s++) begin
      found = 1'b0;
      v[s]  = IdleIn[s];
      for (int p = 0; p < NumPads; p++) begin
        if (!found && cfg_m[p][2] && cfg_m[p][1:0] == s[1:0]) begin
          v[s]  = pads[p];
          found = 1'b1;
        end
      end
    end
    return v;
  endfunction

  function automatic logic [31:0] exp_reg(input int a);
    logic [31:0] v;
    v = '0;
    if (a < NumPads) begin
      v[2:0] = cfg_m[a];
    end else if (a == OutAddr) begin
      v[NumPads-1:0] = gpio_out_m;
    end else if (a == OeAddr) begin
      v[NumPads-1:0] = gpio_oe_m;
    end else if (a == InAddr) begin
      v[NumPads-1:0] = pad_i;
    end
    return v;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // bus access and checks
  //////////////////////////////////////////////////////////////////////

  task automatic bus_access(input logic wr, input int a, input logic [31:0] data,
                            output logic [31:0] rd, output logic err);
    int wait_cnt;
    @(negedge clk_i);
    reg_valid_i = 1'b1;
    reg_write_i = wr;
    reg_addr_i  = a[7:0];
    reg_wdata_i = data;
    @(negedge clk_i);
    reg_valid_i = 1'b0;
    wait_cnt    = 0;
    while (reg_ready_o !== 1'b1 && wait_cnt < 8) begin
      @(negedge clk_i);
      wait_cnt++;
    end
    if (reg_ready_o !== 1'b1) begin
      $display("register bus did not answer for address %0d at time %0t", a, $time);
      $display("Errors found");
      $finish;
    end else begin
      rd  = reg_rdata_o;
      err = reg_error_o;
    end
  endtask

  task automatic write_reg(input int a, input logic [31:0] data);
    logic [31:0] rd;
    logic        err;
    bus_access(1'b1, a, data, rd, err);
    if (err !== 1'b0) begin
      $display("Fail at %0t: write to %0d returned an error", $time, a);
      errors++;
    end
    if (a < NumPads) begin
      cfg_m[a] = data[2:0];
    end else if (a == OutAddr) begin
      gpio_out_m = data[NumPads-1:0];
    end else if (a == OeAddr) begin
      gpio_oe_m = data[NumPads-1:0];
    end
  endtask

  task automatic check_reg(input int a);
    logic [31:0] rd;
    logic        err;
    bus_access(1'b0, a, '0, rd, err);
    if (err !== 1'b0 || rd !== exp_reg(a)) begin
      $display("Fail at %0t: read of %0d gave %h error %b, expected %h",
               $time, a, rd, err, exp_reg(a));
      errors++;
    end
  endtask

  task automatic check_all_regs();
    for (int a = 0; a <= InAddr; a++) begin
      check_reg(a);
    end
  endtask

  task automatic check_pads();
    if (pad_o !== exp_pad(1'b0) || pad_oe_o !== exp_pad(1'b1)) begin
      $display("Fail at %0t: pads out %h oe %h, expected out %h oe %h",
               $time, pad_o, pad_oe_o, exp_pad(1'b0), exp_pad(1'b1));
      errors++;
    end
  endtask

  task automatic report_test(input int num, input string name, input int start);
    $display("test %0d %s finished with %0d errors", num, name, errors - start);
  endtask

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    seed         = 32'hbd8;
    errors       = 0;
    clk_i        = 1'b0;
    rst_n_i      = 1'b0;
    reg_valid_i  = 1'b0;
    reg_write_i  = 1'b0;
    reg_addr_i   = '0;
    reg_wdata_i  = '0;
    periph_out_i = '0;
    periph_oe_i  = '0;
    pad_i        = '0;
    gpio_out_m   = '0;
    gpio_oe_m    = '0;
    for (int p = 0; p < NumPads; p++) begin
      cfg_m[p] = '0;
    end
    repeat (4) @(negedge clk_i);
    rst_n_i = 1'b1;

    // reset state, synchronizers settle on pad_i low
    mark = errors;
    repeat (3) @(negedge clk_i);
    if (pad_oe_o !== '0 || periph_in_o !== IdleIn) begin
      $display("Fail at %0t: after reset oe %h periph_in %h", $time, pad_oe_o, periph_in_o);
      errors++;
    end
    check_all_regs();
    report_test(1, "reset values", mark);

    mark = errors;
    for (int r = 0; r < 8; r++) begin
      write_reg(OutAddr, $random(seed));
      write_reg(OeAddr, $random(seed));
      check_pads();
      check_reg(OutAddr);
      check_reg(OeAddr);
    end
    report_test(2, "gpio output", mark);

    mark = errors;
    for (int r = 0; r < 6; r++) begin
      for (int p = 0; p < NumPads; p++) begin
        write_reg(p, $random(seed));
      end
      for (int k = 0; k < 4; k++) begin
        @(negedge clk_i);
        periph_out_i = 4'($random(seed));
        periph_oe_i  = 4'($random(seed));
        @(negedge clk_i);
        check_pads();
      end
      check_all_regs();
    end
    report_test(3, "peripheral output", mark);

    // sparse peripheral mode so that idle inputs show up
    mark = errors;
    for (int r = 0; r < 8; r++) begin
      for (int p = 0; p < NumPads; p++) begin
        wval    = $random(seed);
        wval[2] = (wval[4:3] == 2'b00);
        write_reg(p, wval);
      end
      @(negedge clk_i);
      pad_i = NumPads'($random(seed));
      repeat (3) @(negedge clk_i);
      if (periph_in_o !== exp_periph_in(pad_i)) begin
        $display("Fail at %0t: periph_in %h, expected %h",
                 $time, periph_in_o, exp_periph_in(pad_i));
        errors++;
      end
      check_reg(InAddr);
    end
    report_test(4, "input routing", mark);

    mark = errors;
    for (int r = 0; r < 10; r++) begin
      wval = $random(seed);
      if (r % 2 == 0) begin
        bus_access(1'b1, InAddr, wval, rdata, rerr);
        addr = InAddr;
      end else begin
        addr = InAddr + 1 + (wval[7:0] % (255 - InAddr));
        bus_access(wval[8], addr, $random(seed), rdata, rerr);
      end
      if (rerr !== 1'b1) begin
        $display("Fail at %0t: access to %0d gave no error", $time, addr);
        errors++;
      end
      check_all_regs();
    end
    report_test(5, "bad accesses", mark);

    $display("5 tests run, %0d errors in total", errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// File: astral_pinmux.f
logic/pinmux_cfg_pkg.sv
logic/pinmux_map_pkg.sv
logic/pinmux_cfg_regs.sv
logic/pad_slice.sv
logic/pinmux_in_router.sv
logic/astral_pinmux.sv
verification/astral_pinmux_sva.sv
verification/tb_astral_pinmux.sv

// File: Makefile
# Verilator build and run for the pad multiplexer testbench

TOP := tb_astral_pinmux

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 -f astral_pinmux.f \
		--top-module $(TOP) -o V$(TOP)

run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^No errors$$"

lint:
	verilator --lint-only --timing --assert -f astral_pinmux.f \
		--top-module $(TOP)

clean:
	rm -rf obj_dir
